// ==== design/vdp_fsm.sv ====
/*
 * vdp_fsm: Graphics I fetch ring, pattern shifter and colour select,
 * with the raster flags delayed to match the pixel pipeline
 */
`timescale 1ns/1ps

module vdp_fsm (
    input  logic                pxclk,
    input  logic                reset,
    input  vdp_pkg::px_coord_t  px_col,
    input  vdp_pkg::px_coord_t  px_row,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                vid_active,
    input  logic                bdr_active,
    input  logic                last_pixel,
    input  logic                col_last,
    input  logic                row_last,
    input  logic [3:0]          name_base,
    input  logic [7:0]          color_base,
    input  logic [2:0]          pattern_base,
    input  vdp_pkg::color_t     fg_color,
    input  vdp_pkg::color_t     bg_color,
    input  logic                blank,
    input  vdp_pkg::vram_data_t dma_dout,
    output vdp_pkg::vram_addr_t dma_addr,
    output logic                dma_rd_tick,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic                vid_active_out,
    output logic                bdr_active_out,
    output logic                last_pixel_out,
    output logic                col_last_out,
    output logic                row_last_out,
    output vdp_pkg::color_t     color_out
);

    logic [7:0]          ring_reg, ring_next;          // one-hot, indexed by slot_t
    logic [7:0]          ring_prev;
    vdp_pkg::vram_data_t name_reg, name_next;
    vdp_pkg::vram_data_t pattern_reg, pattern_next;
    vdp_pkg::vram_data_t color_reg, color_next;
    logic                pixel_reg, pixel_next;        // pattern bit, 1 clock late
    vdp_pkg::color_t     color_out_reg, color_out_next;
    vdp_pkg::color_t     nibble;
    logic                rd_tick_reg, rd_tick_next;
    vdp_pkg::vram_addr_t addr_reg, addr_next;
    logic [9:0]          tile_reg, tile_next;
    logic [9:0]          tile_row_reg, tile_row_next;  // first tile of the current tile row
    logic [9:0]          tile_cur;
    logic                first_tile;
    logic [6:0]          flags_in;
    logic [vdp_pkg::pipe_len-1:0][6:0] pipe_reg;
    logic                vid_early, bdr_early;

    // ******************************
    // registers
    // ******************************
    always_ff @(posedge pxclk) begin
        if (reset) begin
            ring_reg      <= 8'b1 << vdp_pkg::slot_name;
            rd_tick_reg   <= 1'b0;
            tile_reg      <= '0;
            tile_row_reg  <= '0;
            color_out_reg <= '0;
            pipe_reg      <= '0;
        end else begin
            ring_reg      <= ring_next;
            rd_tick_reg   <= rd_tick_next;
            tile_reg      <= tile_next;
            tile_row_reg  <= tile_row_next;
            color_out_reg <= color_out_next;
            pipe_reg      <= {flags_in, pipe_reg[vdp_pkg::pipe_len-1:1]};
        end
    end

    always_ff @(posedge pxclk) begin
        name_reg    <= name_next;
        pattern_reg <= pattern_next;
        color_reg   <= color_next;
        pixel_reg   <= pixel_next;
        addr_reg    <= addr_next;
    end

    assign flags_in = {hsync, vsync, vid_active, bdr_active, last_pixel, col_last, row_last};
    assign vid_early = pipe_reg[1][4];   // reaches the outputs next clock
    assign bdr_early = pipe_reg[1][3];

    // name slot of the first tile decides save or reload of the row start
    assign first_tile = vid_active && (px_col == vdp_pkg::win_col_first + 10'd1);
    assign tile_cur   = (first_tile && px_row[3:0] != 4'd0) ? tile_row_reg : tile_reg;

    assign nibble = pixel_reg ? color_reg[7:4] : color_reg[3:0];

    // ******************************
    // fetch ring
    // ******************************
    always_comb begin
        ring_next      = ring_reg;
        name_next      = name_reg;
        pattern_next   = pattern_reg;
        color_next     = color_reg;
        pixel_next     = pixel_reg;
        color_out_next = color_out_reg;
        rd_tick_next   = rd_tick_reg;
        addr_next      = addr_reg;
        tile_next      = tile_reg;
        tile_row_next  = tile_row_reg;

        if (vsync) begin
            tile_next     = '0;    // new frame
            tile_row_next = '0;
        end

        // one slot per picture pixel, i.e. two pxclk
        if (px_col[0]) begin
            rd_tick_next = 1'b0;
            ring_next    = {ring_reg[6:0], ring_reg[7]};
            pattern_next = {pattern_reg[6:0], 1'b0};
            pixel_next   = pattern_reg[7];

            if (vid_early)
                color_out_next = (blank || nibble == 4'd0) ? bg_color : nibble;
            else if (bdr_early)
                color_out_next = bg_color;
            else
                color_out_next = '0;         // blanking interval

            if (vid_active) begin
                case (1'b1)
                    ring_reg[vdp_pkg::slot_name]: begin
                        addr_next    = {name_base, tile_cur};
                        rd_tick_next = 1'b1;
                        tile_next    = tile_cur;
                        if (first_tile && px_row[3:0] == 4'd0)
                            tile_row_next = tile_reg;   // top line of a tile row
                    end
                    ring_reg[vdp_pkg::slot_cpu0]: begin
                        name_next = dma_dout;
                    end
                    ring_reg[vdp_pkg::slot_pattern]: begin
                        // rows are doubled, so row bits 3:1 pick the pattern line
                        addr_next    = {pattern_base, name_reg, px_row[3:1]};
                        rd_tick_next = 1'b1;
                    end
                    ring_reg[vdp_pkg::slot_color]: begin
                        pattern_next = dma_dout;
                        addr_next    = {color_base, 1'b0, name_reg[7:3]};   // one byte per 8 names
                        rd_tick_next = 1'b1;
                    end
                    ring_reg[vdp_pkg::slot_latch]: begin
                        color_next = dma_dout;
                    end
                    ring_reg[vdp_pkg::slot_advance]: begin
                        tile_next = tile_reg + 10'd1;
                    end
                    default: ;      // idle host slots
                endcase
            end
        end

        if (!vid_active)
            ring_next = 8'b1 << vdp_pkg::slot_name;    // realign outside the window
    end

    assign dma_addr    = addr_reg;
    assign dma_rd_tick = rd_tick_reg;
    assign color_out   = color_out_reg;
    assign {hsync_out, vsync_out, vid_active_out, bdr_active_out,
            last_pixel_out, col_last_out, row_last_out} = pipe_reg[0];

    // ******************************
    // checks
    // ******************************
    assign ring_prev = {ring_reg[0], ring_reg[7:1]};   // slot that issued the current tick

    a_ring_onehot: assert property (@(posedge pxclk) disable iff (reset)
        $onehot(ring_reg));

    a_tick_slot: assert property (@(posedge pxclk) disable iff (reset)
        dma_rd_tick |-> (ring_prev[vdp_pkg::slot_name] ||
                         ring_prev[vdp_pkg::slot_pattern] ||
                         ring_prev[vdp_pkg::slot_color]));

    // host register updates land between frames, never mid-picture
    a_regs_stable: assert property (@(posedge pxclk) disable iff (reset)
        vid_active |-> $stable({name_base, color_base, pattern_base,
                                fg_color, bg_color, blank}));

endmodule

// ==== design/vdp_pkg.sv ====
/*
 * vdp_pkg: raster constants, vector types and the fetch ring slots
 * shared by the TMS9918-style background display path
 */
package vdp_pkg;

    // ******************************
    // vector types
    // ******************************
    typedef logic [9:0]  px_coord_t;        // raster column or row
    typedef logic [13:0] vram_addr_t;       // 16 KB byte address
    typedef logic [7:0]  vram_data_t;
    typedef logic [3:0]  color_t;           // TMS9918 colour index

    // ******************************
    // 640x480 raster
    // ******************************
    localparam px_coord_t h_total      = 10'd800;
    localparam px_coord_t h_active     = 10'd640;
    localparam px_coord_t h_sync_start = 10'd656;
    localparam px_coord_t h_sync_end   = 10'd752;

    localparam px_coord_t v_total      = 10'd525;
    localparam px_coord_t v_active     = 10'd480;
    localparam px_coord_t v_sync_start = 10'd490;
    localparam px_coord_t v_sync_end   = 10'd492;

    // 256x192 picture, every pixel and line doubled
    localparam px_coord_t win_col_first = 10'd64;
    localparam px_coord_t win_col_last  = 10'd575;
    localparam px_coord_t win_row_first = 10'd48;   // multiple of 16
    localparam px_coord_t win_row_last  = 10'd431;

    localparam int pipe_len = 12;   // 6 doubled pixels

    // eight-slot fetch ring, one slot per picture pixel
    typedef enum logic [2:0] {
        slot_name,
        slot_cpu0,
        slot_pattern,
        slot_color,
        slot_latch,
        slot_cpu1,
        slot_cpu2,
        slot_advance
    } slot_t;

endpackage

// ==== design/vdp_regs.sv ====
/*
 * vdp_regs: TMS9918 registers 0..7 written by the host strobe,
 * decoded into blank, table bases and colours
 */
`timescale 1ns/1ps

module vdp_regs (
    input  logic                pxclk,
    input  logic                reset,
    input  logic                reg_wr,
    input  logic [2:0]          reg_addr,
    input  vdp_pkg::vram_data_t reg_data,
    output logic [3:0]          name_base,
    output logic [7:0]          color_base,
    output logic [2:0]          pattern_base,
    output vdp_pkg::color_t     fg_color,
    output vdp_pkg::color_t     bg_color,
    output logic                blank
);

    vdp_pkg::vram_data_t regs [8];   // mode bits in 0 and 1 are kept but not decoded

    always_ff @(posedge pxclk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wr) begin
            regs[reg_addr] <= reg_data;
        end
    end

    // ******************************
    // field decode
    // ******************************

    // R1 bit 6 enables the display, so a cleared R1 blanks it
    assign blank        = ~regs[1][6];
    assign name_base    = regs[2][3:0];     // x 1024
    assign color_base   = regs[3];          // x 64
    assign pattern_base = regs[4][2:0];     // x 2048
    assign fg_color     = regs[7][7:4];     // text colour
    assign bg_color     = regs[7][3:0];     // backdrop

endmodule

// ==== design/vdp_top.sv ====
/*
 * vdp_top: TMS9918-style background display path on a 640x480 raster
 */
`timescale 1ns/1ps

module vdp_top (
    input  logic                pxclk,
    input  logic                reset,
    input  logic                reg_wr,
    input  logic [2:0]          reg_addr,
    input  vdp_pkg::vram_data_t reg_data,
    input  logic                vram_wr,
    input  vdp_pkg::vram_addr_t vram_waddr,
    input  vdp_pkg::vram_data_t vram_wdata,
    output logic                hsync,
    output logic                vsync,
    output logic                vid_active,
    output logic                bdr_active,
    output logic                last_pixel,
    output logic                col_last,
    output logic                row_last,
    output vdp_pkg::color_t     color_out
);

    // raw raster, before the fetch pipeline delay
    vdp_pkg::px_coord_t  px_col, px_row;
    logic                raw_hsync, raw_vsync, raw_vid_active, raw_bdr_active;
    logic                raw_last_pixel, raw_col_last, raw_row_last;

    logic [3:0]          name_base;
    logic [7:0]          color_base;
    logic [2:0]          pattern_base;
    vdp_pkg::color_t     fg_color, bg_color;
    logic                blank;

    vdp_pkg::vram_addr_t dma_addr;
    logic                dma_rd_tick;
    vdp_pkg::vram_data_t dma_dout;

    vga_timing timing_i (
        .pxclk(pxclk), .reset(reset), .px_col(px_col), .px_row(px_row),
        .hsync(raw_hsync), .vsync(raw_vsync), .vid_active(raw_vid_active),
        .bdr_active(raw_bdr_active), .last_pixel(raw_last_pixel),
        .col_last(raw_col_last), .row_last(raw_row_last)
    );

    vdp_regs regs_i (
        .pxclk(pxclk), .reset(reset), .reg_wr(reg_wr), .reg_addr(reg_addr),
        .reg_data(reg_data), .name_base(name_base), .color_base(color_base),
        .pattern_base(pattern_base), .fg_color(fg_color), .bg_color(bg_color),
        .blank(blank)
    );

    vram vram_i (
        .pxclk(pxclk), .vram_wr(vram_wr), .vram_waddr(vram_waddr),
        .vram_wdata(vram_wdata), .dma_addr(dma_addr), .dma_rd_tick(dma_rd_tick),
        .dma_dout(dma_dout)
    );

    vdp_fsm fsm_i (
        .pxclk(pxclk), .reset(reset), .px_col(px_col), .px_row(px_row),
        .hsync(raw_hsync), .vsync(raw_vsync), .vid_active(raw_vid_active),
        .bdr_active(raw_bdr_active), .last_pixel(raw_last_pixel),
        .col_last(raw_col_last), .row_last(raw_row_last),
        .name_base(name_base), .color_base(color_base), .pattern_base(pattern_base),
        .fg_color(fg_color), .bg_color(bg_color), .blank(blank),
        .dma_dout(dma_dout), .dma_addr(dma_addr), .dma_rd_tick(dma_rd_tick),
        .hsync_out(hsync), .vsync_out(vsync), .vid_active_out(vid_active),
        .bdr_active_out(bdr_active), .last_pixel_out(last_pixel),
        .col_last_out(col_last), .row_last_out(row_last), .color_out(color_out)
    );

endmodule

// ==== design/vga_timing.sv ====
/*
 * vga_timing: 800x525 raster counters with registered sync, picture
 * window, border and end-of-line/frame flags
 */
`timescale 1ns/1ps

module vga_timing (
    input  logic               pxclk,
    input  logic               reset,
    output vdp_pkg::px_coord_t px_col,
    output vdp_pkg::px_coord_t px_row,
    output logic               hsync,
    output logic               vsync,
    output logic               vid_active,     // picture window
    output logic               bdr_active,     // visible but outside the window
    output logic               last_pixel,
    output logic               col_last,
    output logic               row_last
);

    vdp_pkg::px_coord_t col_reg, row_reg;
    vdp_pkg::px_coord_t col_nxt, row_nxt;
    logic               visible_nxt;
    logic               window_nxt;

    // counters wrap at the raster totals
    always_comb begin
        col_nxt = col_reg + 10'd1;
        row_nxt = row_reg;
        if (col_reg == vdp_pkg::h_total - 10'd1) begin
            col_nxt = '0;
            if (row_reg == vdp_pkg::v_total - 10'd1)
                row_nxt = '0;
            else
                row_nxt = row_reg + 10'd1;
        end
    end

    assign visible_nxt = (col_nxt < vdp_pkg::h_active) && (row_nxt < vdp_pkg::v_active);
    assign window_nxt  = (col_nxt >= vdp_pkg::win_col_first) &&
                         (col_nxt <= vdp_pkg::win_col_last) &&
                         (row_nxt >= vdp_pkg::win_row_first) &&
                         (row_nxt <= vdp_pkg::win_row_last);

    // flags are decoded from the next count so they line up with px_col/px_row
    always_ff @(posedge pxclk) begin
        if (reset) begin
            col_reg    <= '0;
            row_reg    <= '0;
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            vid_active <= 1'b0;
            bdr_active <= 1'b1;     // column 0, row 0 is visible border
            last_pixel <= 1'b0;
            col_last   <= 1'b0;
            row_last   <= 1'b0;
        end else begin
            col_reg    <= col_nxt;
            row_reg    <= row_nxt;
            hsync      <= (col_nxt >= vdp_pkg::h_sync_start) && (col_nxt < vdp_pkg::h_sync_end);
            vsync      <= (row_nxt >= vdp_pkg::v_sync_start) && (row_nxt < vdp_pkg::v_sync_end);
            vid_active <= window_nxt;
            bdr_active <= visible_nxt && !window_nxt;
            last_pixel <= (col_nxt == vdp_pkg::h_active - 10'd1) &&
                          (row_nxt == vdp_pkg::v_active - 10'd1);
            col_last   <= (col_nxt == vdp_pkg::h_total - 10'd1);
            row_last   <= (row_nxt == vdp_pkg::v_total - 10'd1);   // whole last row
        end
    end

    assign px_col = col_reg;
    assign px_row = row_reg;

    // picture window lies inside the visible area
    a_window_visible: assert property (@(posedge pxclk) disable iff (reset)
        vid_active |-> (px_col < vdp_pkg::h_active) && (px_row < vdp_pkg::v_active));

endmodule

// ==== design/vram.sv ====
/*
 * vram: 16K x 8 video memory with a host write port and a
 * registered read port for the fetch engine
 */
`timescale 1ns/1ps

module vram (
    input  logic                pxclk,
    input  logic                vram_wr,
    input  vdp_pkg::vram_addr_t vram_waddr,
    input  vdp_pkg::vram_data_t vram_wdata,
    input  vdp_pkg::vram_addr_t dma_addr,
    input  logic                dma_rd_tick,
    output vdp_pkg::vram_data_t dma_dout
);

    vdp_pkg::vram_data_t mem [16384];
    vdp_pkg::vram_data_t dout_reg;

    // host side, no stall
    always_ff @(posedge pxclk) begin
        if (vram_wr)
            mem[vram_waddr] <= vram_wdata;
    end

    // read data valid the clock after the tick
    always_ff @(posedge pxclk) begin
        if (dma_rd_tick)
            dout_reg <= mem[dma_addr];
    end

    assign dma_dout = dout_reg;

    // the fetch engine must present a real address with every read
    a_dma_addr_known: assert property (@(posedge pxclk)
        dma_rd_tick |-> !$isunknown(dma_addr));

endmodule

// ==== project.f ====
+incdir+sim
design/vdp_pkg.sv
design/vga_timing.sv
design/vdp_regs.sv
design/vram.sv
design/vdp_fsm.sv
design/vdp_top.sv
sim/vdp_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the VDP testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module vdp_tb -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vvdp_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation returned status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// ==== sim/vdp_model.svh ====
/*
 * Graphics I reference model, built on the testbench mirrors
 * of the VRAM and the VDP register file
 */

vdp_pkg::vram_data_t vram_mirror [16384];
vdp_pkg::vram_data_t reg_mirror [8];

// display enable is R1 bit 6
function automatic bit display_blanked();
    return !reg_mirror[1][6];
endfunction

function automatic vdp_pkg::color_t backdrop();
    return reg_mirror[7][3:0];     // low nibble of R7
endfunction

// ******************************
// picture pixel at x, y of the 256x192 picture
// ******************************
function automatic vdp_pkg::color_t expected_pixel(input int x, input int y);
    vdp_pkg::vram_addr_t name_addr;
    vdp_pkg::vram_addr_t patt_addr;
    vdp_pkg::vram_addr_t color_addr;
    vdp_pkg::vram_data_t name;
    vdp_pkg::vram_data_t patt;
    vdp_pkg::vram_data_t colors;
    logic [2:0]          col_bit;
    vdp_pkg::color_t     pix;
    // name table holds 32 names per tile row
    name_addr  = vdp_pkg::vram_addr_t'(int'(reg_mirror[2][3:0]) * 1024 + (y / 8) * 32 + x / 8);
    name       = vram_mirror[name_addr];
    patt_addr  = vdp_pkg::vram_addr_t'(int'(reg_mirror[4][2:0]) * 2048 + int'(name) * 8 + y % 8);
    color_addr = vdp_pkg::vram_addr_t'(int'(reg_mirror[3]) * 64 + int'(name) / 8);
    patt       = vram_mirror[patt_addr];
    colors     = vram_mirror[color_addr];
    col_bit    = 3'(x % 8);
    pix = patt[3'd7 - col_bit] ? colors[7:4] : colors[3:0];   // msb is the leftmost pixel
    if (display_blanked() || pix == 4'd0)
        pix = backdrop();           // colour 0 is transparent
    return pix;
endfunction

// ==== sim/vdp_tb.sv ====
/*
 * vdp_tb: random VRAM and register stimulus for the VDP background path,
 * with raster and pixel checks against a Graphics I model
 */
`timescale 1ns/1ps

module vdp_tb;

    localparam int     clk_period      = 10;
    localparam int     frame_clocks    = 420000;
    localparam longint watchdog_clocks = 16 + 16384 + 5 * frame_clocks;

    logic                pxclk, reset;
    logic                reg_wr;
    logic [2:0]          reg_addr;
    vdp_pkg::vram_data_t reg_data;
    logic                vram_wr;
    vdp_pkg::vram_addr_t vram_waddr;
    vdp_pkg::vram_data_t vram_wdata;
    logic                hsync, vsync, vid_active, bdr_active;
    logic                last_pixel, col_last, row_last;
    vdp_pkg::color_t     color_out;

    int seed;

    // raster tracking in the checker
    bit flags_seen, hs_seen, vs_seen;
    bit prev_hsync, prev_vsync, prev_vid;
    int hs_period, hs_width, vs_lines, vs_width, vid_n, vid_lines;
    int col_pos, row_pos;       // raster position shown at the outputs

    `include "vdp_model.svh"

    vdp_top vdp_top_i (.*);

    initial begin
        pxclk = 1'b0;
        forever #(clk_period / 2) pxclk = ~pxclk;
    end

    // ******************************
    // failure reporting and compares
    // ******************************
    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_color(input vdp_pkg::color_t got, input vdp_pkg::color_t exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %0b, expected %0b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input vdp_pkg::px_coord_t got, input vdp_pkg::px_coord_t exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ******************************
    // stimulus helpers
    // ******************************
    function automatic vdp_pkg::vram_data_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic write_reg(input logic [2:0] addr, input vdp_pkg::vram_data_t data);
        @(negedge pxclk);
        reg_wr            = 1'b1;
        reg_addr          = addr;
        reg_data          = data;
        reg_mirror[addr]  = data;
    endtask

    task automatic release_reg_bus();
        @(negedge pxclk);
        reg_wr = 1'b0;
    endtask

    task automatic fill_vram();
        for (int a = 0; a < 16384; a++) begin
            @(negedge pxclk);
            vram_wr                 = 1'b1;
            vram_waddr              = vdp_pkg::vram_addr_t'(a);
            vram_wdata              = rand_byte();
            vram_mirror[vram_waddr] = vram_wdata;
        end
        @(negedge pxclk);
        vram_wr = 1'b0;
    endtask

    task automatic wait_vsync_rise();
        @(negedge pxclk);
        while (vsync) @(negedge pxclk);
        while (!vsync) @(negedge pxclk);
    endtask

    initial begin
        seed       = 32'hc445;
        reset      = 1'b1;
        reg_wr     = 1'b0;
        reg_addr   = '0;
        reg_data   = '0;
        vram_wr    = 1'b0;
        vram_waddr = '0;
        vram_wdata = '0;
        for (int i = 0; i < 8; i++) begin
            reg_mirror[i] = '0;
        end
        repeat (16) @(negedge pxclk);
        reset = 1'b0;
        fill_vram();

        wait_vsync_rise();                          // frame 1, random tables, display on
        for (int i = 0; i < 8; i++) begin
            write_reg(3'(i), rand_byte());
        end
        write_reg(3'd1, rand_byte() | 8'h40);
        release_reg_bus();

        wait_vsync_rise();                          // frame 2 blanked
        write_reg(3'd1, rand_byte() & 8'hbf);
        write_reg(3'd7, rand_byte());
        release_reg_bus();

        wait_vsync_rise();                          // frame 3 with new bases
        write_reg(3'd1, rand_byte() | 8'h40);
        write_reg(3'd2, rand_byte());
        write_reg(3'd3, rand_byte());
        write_reg(3'd4, rand_byte());
        write_reg(3'd7, rand_byte());
        release_reg_bus();

        wait_vsync_rise();
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(watchdog_clocks * clk_period);
        $display("watchdog expired before the third frame ended, the run timed out");
        abort_run();
    end

    // ******************************
    // output checker, sampled just before each rising edge
    // ******************************
    initial begin
        flags_seen = 1'b0;
        hs_seen    = 1'b0;
        vs_seen    = 1'b0;
        prev_hsync = 1'b0;
        prev_vsync = 1'b0;
        prev_vid   = 1'b0;
        hs_period  = 0;
        hs_width   = 0;
        vs_lines   = 0;
        vs_width   = 0;
        vid_n      = 0;
        vid_lines  = 0;
        col_pos    = 0;
        row_pos    = 0;
    end

    always @(posedge pxclk) begin
        if (!reset && !flags_seen) begin
            if (hsync | vsync | vid_active | bdr_active | last_pixel | col_last | row_last) begin
                flags_seen = 1'b1;
                col_pos    = 0;         // first flag shows column 0, row 0
                row_pos    = 0;
                check_flag(bdr_active, 1'b1, "first raster flag after reset");
            end else begin
                check_color(color_out, '0, "colour before the raster starts");
            end
        end
        if (!reset && flags_seen) begin
            check_flag(vid_active & bdr_active, 1'b0, "window and border overlap");
            check_flag(col_last, col_pos == 799, "last column flag");
            check_flag(row_last, row_pos == 524, "last row flag");
            check_flag(last_pixel, (col_pos == 639) && (row_pos == 479),
                       "last visible pixel flag");
            hs_period++;
            if (hsync)
                hs_width++;
            if (hsync && !prev_hsync) begin
                if (hs_seen)
                    check_count(10'(hs_period), 10'd800, "hsync period");
                hs_seen   = 1'b1;
                hs_period = 0;
                vs_lines++;
                if (vsync)
                    vs_width++;         // lines inside the vsync pulse
            end
            if (!hsync && prev_hsync) begin
                check_count(10'(hs_width), 10'd96, "hsync width");
                hs_width = 0;
            end
            if (vsync && !prev_vsync) begin
                if (vs_seen)
                    check_count(10'(vs_lines), 10'd525, "lines per frame");
                check_count(10'(vid_lines), 10'd384, "picture lines per frame");
                vs_seen   = 1'b1;
                vs_lines  = 0;
                vid_lines = 0;
            end
            if (!vsync && prev_vsync) begin
                check_count(10'(vs_width), 10'd2, "vsync width in lines");
                vs_width = 0;
            end
            if (vid_active) begin
                if (!prev_vid)
                    vid_n = 0;
                check_color(color_out, expected_pixel(vid_n / 2, vid_lines / 2), "picture pixel");
                vid_n++;
            end else if (prev_vid) begin
                check_count(10'(vid_n), 10'd512, "picture width");
                vid_lines++;
            end
            if (bdr_active)
                check_color(color_out, backdrop(), "border colour");
            else if (!vid_active)
                check_color(color_out, '0, "colour outside the visible area");
            prev_hsync = hsync;
            prev_vsync = vsync;
            prev_vid   = vid_active;
            col_pos++;
            if (col_pos == 800) begin
                col_pos = 0;
                row_pos = (row_pos == 524) ? 0 : row_pos + 1;
            end
        end
    end

endmodule
